// File: build.f
cpu_pkg.sv
control_decode.sv
register_file.sv
alu_execute.sv
memory_writeback.sv
pipeline_core.sv
tb_pipeline_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_pipeline_core -f build.f -o tb_sim
result=$(./obj_dir/tb_sim)
echo "$result"
if echo "$result" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

// File: tb_pipeline_core.sv
module tb_pipeline_core;

    localparam int TIMEOUT_CYCLES = 2000;  // Program runs about 200 cycles

    logic           clk;
    logic           rst;
    cpu_pkg::word_t instr;
    logic           instr_valid;
    cpu_pkg::word_t in_port;
    cpu_pkg::word_t out_port;
    logic           out_valid;
    logic           redirect;
    cpu_pkg::word_t redirect_target;

    int cycles;
    int test_errors;
    int tests_passed;
    int tests_failed;
    int out_pulses;    // out_valid cycles seen by the monitor
    int outs_checked;  // out_valid cycles consumed by checks

    pipeline_core #(
        .MEM_ADDR_WIDTH(8)
    ) UUT (
        .clk, .rst, .instr, .instr_valid, .in_port,
        .out_port, .out_valid, .redirect, .redirect_target
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run went past %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (!rst && out_valid) begin
            out_pulses++;
        end
    end

    function automatic cpu_pkg::word_t encode(input cpu_pkg::opcode_t op,
                                              input cpu_pkg::reg_addr_t rd,
                                              input cpu_pkg::reg_addr_t rs);
        return {op, rd, rs, 5'b00000};
    endfunction

    // Accepted at the next edge, returns 2 units after it
    task automatic issue_word(input cpu_pkg::word_t word);
        instr       = word;
        instr_valid = 1'b1;
        @(posedge clk);
        #2;
        instr       = '0;
        instr_valid = 1'b0;
    endtask

    task automatic issue_nops();
        repeat (3) issue_word(encode(cpu_pkg::OP_NOP, 3'd0, 3'd0));
    endtask

    task automatic load_imm(input cpu_pkg::reg_addr_t rd, input cpu_pkg::word_t value);
        issue_word(encode(cpu_pkg::OP_LDM, rd, 3'd0));
        issue_word(value);
    endtask

    task automatic check_out(input cpu_pkg::word_t expected, input string name);
        int   waited;
        logic seen;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < 8) begin
            @(posedge clk);
            #2;
            waited++;
            seen = out_valid;
        end
        assert (seen) else begin
            $display("ERROR at %0t: out_valid never rose for %s", $time, name);
            test_errors++;
        end
        if (seen) begin
            outs_checked++;
            assert (out_port === expected) else begin
                $display("MISMATCH at %0t: out_port (%s) expected %h, got %h",
                         $time, name, expected, out_port);
                test_errors++;
            end
        end
    endtask

    task automatic out_and_check(input cpu_pkg::reg_addr_t rd, input cpu_pkg::word_t expected,
                                 input string name);
        issue_word(encode(cpu_pkg::OP_OUT, rd, 3'd0));
        check_out(expected, name);
    endtask

    // Jump was accepted at the last edge, so redirect is live now
    task automatic check_redirect(input logic taken, input cpu_pkg::word_t target,
                                  input string name);
        assert (redirect === taken) else begin
            $display("MISMATCH at %0t: redirect (%s) expected %b, got %b",
                     $time, name, taken, redirect);
            test_errors++;
        end
        if (taken) begin
            assert (redirect_target === target) else begin
                $display("MISMATCH at %0t: redirect_target (%s) expected %h, got %h",
                         $time, name, target, redirect_target);
                test_errors++;
            end
        end
    endtask

    task automatic end_test(input string name);
        repeat (2) @(posedge clk);
        #2;
        assert (out_pulses == outs_checked) else begin
            $display("ERROR at %0t: %0d out_valid cycles seen but %0d expected",
                     $time, out_pulses, outs_checked);
            test_errors++;
            outs_checked = out_pulses;
        end
        if (test_errors == 0) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic reset_and_immediates();
        repeat (5) begin
            assert (out_valid === 1'b0) else begin
                $display("MISMATCH at %0t: out_valid expected 0, got %b", $time, out_valid);
                test_errors++;
            end
            check_redirect(1'b0, '0, "idle after reset");
            @(posedge clk);
            #2;
        end
        load_imm(3'd1, 16'h1234);
        load_imm(3'd2, 16'hABCD);
        issue_nops();
        out_and_check(3'd1, 16'h1234, "R1 after LDM");
        out_and_check(3'd2, 16'hABCD, "R2 after LDM");
        end_test("reset and immediates");
    endtask

    task automatic arithmetic_logic();
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        a = cpu_pkg::word_t'($urandom);
        b = cpu_pkg::word_t'($urandom);
        load_imm(3'd1, a);
        load_imm(3'd2, b);
        issue_nops();
        issue_word(encode(cpu_pkg::OP_MOV, 3'd3, 3'd1));  // Copies keep a intact
        issue_word(encode(cpu_pkg::OP_MOV, 3'd4, 3'd1));
        issue_word(encode(cpu_pkg::OP_MOV, 3'd5, 3'd1));
        issue_word(encode(cpu_pkg::OP_MOV, 3'd6, 3'd1));
        issue_word(encode(cpu_pkg::OP_MOV, 3'd7, 3'd2));
        issue_nops();
        issue_word(encode(cpu_pkg::OP_ADD, 3'd3, 3'd2));
        issue_word(encode(cpu_pkg::OP_SUB, 3'd4, 3'd2));
        issue_word(encode(cpu_pkg::OP_AND, 3'd5, 3'd2));
        issue_word(encode(cpu_pkg::OP_OR, 3'd6, 3'd2));
        issue_nops();
        out_and_check(3'd3, a + b, "ADD");
        out_and_check(3'd4, a - b, "SUB");
        out_and_check(3'd5, a & b, "AND");
        out_and_check(3'd6, a | b, "OR");
        out_and_check(3'd7, b, "MOV");
        issue_word(encode(cpu_pkg::OP_NOT, 3'd1, 3'd0));
        issue_word(encode(cpu_pkg::OP_INC, 3'd2, 3'd0));
        issue_word(encode(cpu_pkg::OP_DEC, 3'd7, 3'd0));
        issue_nops();
        out_and_check(3'd1, ~a, "NOT");
        out_and_check(3'd2, b + 16'd1, "INC");
        out_and_check(3'd7, b - 16'd1, "DEC");
        end_test("arithmetic and logic");
    endtask

    task automatic shifts_and_carry();
        cpu_pkg::word_t src;
        cpu_pkg::word_t shl_expect;
        cpu_pkg::word_t shr_expect;
        src        = 16'h8421;
        shl_expect = src << 4;
        shr_expect = src >> 3;
        load_imm(3'd1, src);
        load_imm(3'd4, 16'h0040);  // Jump target
        issue_nops();
        issue_word(encode(cpu_pkg::OP_SHL, 3'd2, 3'd1));
        issue_word(16'd4);
        issue_word(encode(cpu_pkg::OP_SHR, 3'd3, 3'd1));
        issue_word(16'd3);
        issue_nops();
        out_and_check(3'd2, shl_expect, "SHL by 4");
        out_and_check(3'd3, shr_expect, "SHR by 3");
        issue_word(encode(cpu_pkg::OP_SETC, 3'd0, 3'd0));
        issue_word(encode(cpu_pkg::OP_JC, 3'd4, 3'd0));
        check_redirect(1'b1, 16'h0040, "JC after SETC");
        issue_nops();
        issue_word(encode(cpu_pkg::OP_CLRC, 3'd0, 3'd0));
        issue_word(encode(cpu_pkg::OP_JC, 3'd4, 3'd0));
        check_redirect(1'b0, '0, "JC after CLRC");
        issue_nops();
        end_test("shifts and carry");
    endtask

    task automatic memory_and_stack();
        load_imm(3'd1, 16'h0010);  // Data address
        load_imm(3'd2, 16'hBEEF);
        load_imm(3'd4, 16'h1111);
        load_imm(3'd5, 16'h2222);
        issue_nops();
        issue_word(encode(cpu_pkg::OP_STORE, 3'd2, 3'd1));
        issue_nops();
        issue_word(encode(cpu_pkg::OP_LOAD, 3'd3, 3'd1));
        issue_word(encode(cpu_pkg::OP_PUSH, 3'd4, 3'd0));
        issue_word(encode(cpu_pkg::OP_PUSH, 3'd5, 3'd0));
        issue_nops();
        issue_word(encode(cpu_pkg::OP_POP, 3'd6, 3'd0));
        issue_word(encode(cpu_pkg::OP_POP, 3'd7, 3'd0));
        issue_nops();
        out_and_check(3'd3, 16'hBEEF, "LOAD after STORE");
        out_and_check(3'd6, 16'h2222, "first POP");
        out_and_check(3'd7, 16'h1111, "second POP");
        end_test("memory and stack");
    endtask

    task automatic squashing();
        load_imm(3'd1, 16'd5);
        load_imm(3'd2, 16'd5);
        load_imm(3'd3, 16'h0100);  // Jump target
        load_imm(3'd4, 16'h4444);
        load_imm(3'd5, 16'd3);
        issue_nops();
        issue_word(encode(cpu_pkg::OP_SUB, 3'd1, 3'd2));
        issue_word(encode(cpu_pkg::OP_JZ, 3'd3, 3'd0));
        check_redirect(1'b1, 16'h0100, "JZ after zero SUB");
        issue_nops();
        issue_word(encode(cpu_pkg::OP_JMP, 3'd3, 3'd0));
        check_redirect(1'b1, 16'h0100, "JMP");
        // LDM word is squashed, so its second word decodes as a NOP
        load_imm(3'd4, 16'h0055);
        issue_nops();
        out_and_check(3'd4, 16'h4444, "R4 after squashed LDM");
        issue_word(encode(cpu_pkg::OP_DEC, 3'd1, 3'd0));  // Zero minus one sets negative
        issue_word(encode(cpu_pkg::OP_INC, 3'd5, 3'd0));
        issue_word(encode(cpu_pkg::OP_JN, 3'd3, 3'd0));
        check_redirect(1'b0, '0, "JN after positive INC");
        issue_nops();
        end_test("squashing");
    endtask

    task automatic input_port();
        cpu_pkg::word_t value;
        value   = cpu_pkg::word_t'($urandom);
        in_port = value;
        issue_word(encode(cpu_pkg::OP_IN, 3'd6, 3'd0));
        issue_nops();
        out_and_check(3'd6, value, "IN then OUT");
        end_test("input port");
    endtask

    initial begin
        void'($urandom(32'haf66));
        clk         = 1'b0;
        rst         = 1'b1;
        instr       = '0;
        instr_valid = 1'b0;
        in_port     = '0;
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        reset_and_immediates();
        arithmetic_logic();
        shifts_and_carry();
        memory_and_stack();
        squashing();
        input_port();

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: pipeline_core.sv
module pipeline_core #(
    parameter int MEM_ADDR_WIDTH = 8
) (
    input  logic           clk,
    input  logic           rst,
    input  cpu_pkg::word_t instr,
    input  logic           instr_valid,
    input  cpu_pkg::word_t in_port,
    output cpu_pkg::word_t out_port,
    output logic           out_valid,
    output logic           redirect,
    output cpu_pkg::word_t redirect_target
);

    cpu_pkg::reg_addr_t  src_addr, dest_addr;
    cpu_pkg::word_t      src_value, dest_value;
    logic                jump_taken;

    // Decode to execute
    logic                ex_valid;
    cpu_pkg::alu_op_t    ex_alu_op;
    logic                ex_mem_read, ex_mem_write, ex_push, ex_pop;
    logic                ex_in_port, ex_out_port;
    cpu_pkg::jump_kind_t ex_jump_kind;
    logic                ex_jump_direct, ex_write_back;
    cpu_pkg::reg_addr_t  ex_dest;
    cpu_pkg::word_t      ex_src_value, ex_dest_value, ex_imm;

    // Execute to memory
    logic                mem_valid, mem_read, mem_write, mem_push, mem_pop, mem_out;
    logic                mem_write_back;
    cpu_pkg::reg_addr_t  mem_dest;
    cpu_pkg::word_t      mem_result, mem_store_value;

    // Write-back
    logic                wb_enable;
    cpu_pkg::reg_addr_t  wb_addr;
    cpu_pkg::word_t      wb_data;

    control_decode u_decode (
        .clk, .rst, .instr, .instr_valid, .jump_taken,
        .src_value, .dest_value, .src_addr, .dest_addr,
        .ex_valid, .ex_alu_op, .ex_mem_read, .ex_mem_write,
        .ex_push, .ex_pop, .ex_in_port, .ex_out_port,
        .ex_jump_kind, .ex_jump_direct, .ex_write_back, .ex_dest,
        .ex_src_value, .ex_dest_value, .ex_imm
    );

    register_file u_regs (
        .clk, .rst, .src_addr, .dest_addr,
        .wb_enable, .wb_addr, .wb_data,
        .src_value, .dest_value
    );

    alu_execute u_execute (
        .clk, .rst, .ex_valid, .ex_alu_op, .ex_mem_read, .ex_mem_write,
        .ex_push, .ex_pop, .ex_in_port, .ex_out_port,
        .ex_jump_kind, .ex_jump_direct, .ex_write_back, .ex_dest,
        .ex_src_value, .ex_dest_value, .ex_imm, .in_port,
        .jump_taken, .redirect_target,
        .mem_valid, .mem_read, .mem_write, .mem_push, .mem_pop, .mem_out,
        .mem_write_back, .mem_dest, .mem_result, .mem_store_value
    );

    memory_writeback #(
        .MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)
    ) u_memory (
        .clk, .rst, .mem_valid, .mem_read, .mem_write, .mem_push, .mem_pop,
        .mem_out, .mem_write_back, .mem_dest, .mem_result, .mem_store_value,
        .out_port, .out_valid, .wb_enable, .wb_addr, .wb_data
    );

    assign redirect = jump_taken;  // Taken jump seen in execute

endmodule

// File: memory_writeback.sv
module memory_writeback #(
    parameter int MEM_ADDR_WIDTH = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_valid,
    input  logic               mem_read,
    input  logic               mem_write,
    input  logic               mem_push,
    input  logic               mem_pop,
    input  logic               mem_out,
    input  logic               mem_write_back,
    input  cpu_pkg::reg_addr_t mem_dest,
    input  cpu_pkg::word_t     mem_result,
    input  cpu_pkg::word_t     mem_store_value,
    output cpu_pkg::word_t     out_port,
    output logic               out_valid,
    output logic               wb_enable,
    output cpu_pkg::reg_addr_t wb_addr,
    output cpu_pkg::word_t     wb_data
);

    cpu_pkg::word_t            data_mem [2**MEM_ADDR_WIDTH];
    logic [MEM_ADDR_WIDTH-1:0] sp;
    logic [MEM_ADDR_WIDTH-1:0] rd_addr;
    logic                      out_pend;
    cpu_pkg::word_t            out_hold;

    // POP reads above the current stack pointer
    assign rd_addr = mem_pop ? sp + 1'b1 : mem_result[MEM_ADDR_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            sp        <= '1;  // Stack grows down from the top
            wb_enable <= 1'b0;
            out_pend  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (mem_valid && mem_push) begin
                sp <= sp - 1'b1;
            end else if (mem_valid && mem_pop) begin
                sp <= sp + 1'b1;
            end
            wb_enable <= mem_valid && mem_write_back;
            out_pend  <= mem_valid && mem_out;
            out_valid <= out_pend;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid && mem_push) begin
            data_mem[sp] <= mem_store_value;
        end else if (mem_valid && mem_write) begin
            data_mem[mem_result[MEM_ADDR_WIDTH-1:0]] <= mem_store_value;
        end
        wb_addr  <= mem_dest;
        wb_data  <= mem_read ? data_mem[rd_addr] : mem_result;
        out_hold <= mem_store_value;
        if (out_pend) begin
            out_port <= out_hold;
        end
    end

endmodule

// File: alu_execute.sv
module alu_execute (
    input  logic                clk,
    input  logic                rst,
    input  logic                ex_valid,
    input  cpu_pkg::alu_op_t    ex_alu_op,
    input  logic                ex_mem_read,
    input  logic                ex_mem_write,
    input  logic                ex_push,
    input  logic                ex_pop,
    input  logic                ex_in_port,
    input  logic                ex_out_port,
    input  cpu_pkg::jump_kind_t ex_jump_kind,
    input  logic                ex_jump_direct,
    input  logic                ex_write_back,
    input  cpu_pkg::reg_addr_t  ex_dest,
    input  cpu_pkg::word_t      ex_src_value,
    input  cpu_pkg::word_t      ex_dest_value,
    input  cpu_pkg::word_t      ex_imm,
    input  cpu_pkg::word_t      in_port,
    output logic                jump_taken,
    output cpu_pkg::word_t      redirect_target,
    output logic                mem_valid,
    output logic                mem_read,
    output logic                mem_write,
    output logic                mem_push,
    output logic                mem_pop,
    output logic                mem_out,
    output logic                mem_write_back,
    output cpu_pkg::reg_addr_t  mem_dest,
    output cpu_pkg::word_t      mem_result,
    output cpu_pkg::word_t      mem_store_value
);

    logic           zero_flag, neg_flag, carry_flag;
    cpu_pkg::word_t result;
    logic           carry_next;
    logic           zn_update, carry_update;
    logic           cond_met;

    always_comb begin
        logic [16:0] wide;  // Result with carry or borrow bit
        wide         = '0;
        result       = '0;
        carry_next   = carry_flag;
        zn_update    = 1'b1;
        carry_update = 1'b0;
        case (ex_alu_op)
            cpu_pkg::ALU_NOT: result = ~ex_dest_value;
            cpu_pkg::ALU_INC: begin
                wide         = {1'b0, ex_dest_value} + 17'd1;
                carry_update = 1'b1;
            end
            cpu_pkg::ALU_DEC: begin
                wide         = {1'b0, ex_dest_value} - 17'd1;
                carry_update = 1'b1;
            end
            cpu_pkg::ALU_MOV: result = ex_src_value;
            cpu_pkg::ALU_ADD: begin
                wide         = {1'b0, ex_dest_value} + {1'b0, ex_src_value};
                carry_update = 1'b1;
            end
            cpu_pkg::ALU_SUB: begin
                wide         = {1'b0, ex_dest_value} - {1'b0, ex_src_value};
                carry_update = 1'b1;  // Bit 16 is the borrow
            end
            cpu_pkg::ALU_AND: result = ex_dest_value & ex_src_value;
            cpu_pkg::ALU_OR:  result = ex_dest_value | ex_src_value;
            cpu_pkg::ALU_SHL: begin
                wide         = {1'b0, ex_src_value} << ex_imm[3:0];
                carry_update = 1'b1;
            end
            cpu_pkg::ALU_SHR: begin
                wide         = {ex_src_value, 1'b0} >> ex_imm[3:0];
                result       = wide[16:1];
                carry_next   = wide[0];  // Last bit out on the right
                carry_update = 1'b1;
            end
            default: zn_update = 1'b0;
        endcase
        case (ex_alu_op)
            cpu_pkg::ALU_INC, cpu_pkg::ALU_DEC, cpu_pkg::ALU_ADD,
            cpu_pkg::ALU_SUB, cpu_pkg::ALU_SHL: begin
                result     = wide[15:0];
                carry_next = wide[16];
            end
            cpu_pkg::ALU_SETC: begin
                carry_next   = 1'b1;
                carry_update = 1'b1;
            end
            cpu_pkg::ALU_CLRC: begin
                carry_next   = 1'b0;
                carry_update = 1'b1;
            end
            cpu_pkg::ALU_ADDR: result = ex_push ? ex_dest_value : ex_src_value;
            cpu_pkg::ALU_IMM:  result = ex_imm;
            default: ;
        endcase
        if (ex_in_port) begin
            result = in_port;
        end
    end

    always_comb begin
        case (ex_jump_kind)
            cpu_pkg::JUMP_ZERO:  cond_met = zero_flag;
            cpu_pkg::JUMP_NEG:   cond_met = neg_flag;
            cpu_pkg::JUMP_CARRY: cond_met = carry_flag;
            default:             cond_met = 1'b0;
        endcase
    end

    assign jump_taken      = ex_valid && (ex_jump_direct || cond_met);
    assign redirect_target = ex_dest_value;  // Target lives in the destination register

    always_ff @(posedge clk) begin
        if (rst) begin
            zero_flag      <= 1'b0;
            neg_flag       <= 1'b0;
            carry_flag     <= 1'b0;
            mem_valid      <= 1'b0;
            mem_read       <= 1'b0;
            mem_write      <= 1'b0;
            mem_push       <= 1'b0;
            mem_pop        <= 1'b0;
            mem_out        <= 1'b0;
            mem_write_back <= 1'b0;
        end else begin
            if (ex_valid && zn_update) begin
                zero_flag <= (result == '0);
                neg_flag  <= result[15];
            end
            if (ex_valid && carry_update) begin
                carry_flag <= carry_next;
            end
            mem_valid      <= ex_valid;
            mem_read       <= ex_mem_read;
            mem_write      <= ex_mem_write;
            mem_push       <= ex_push;
            mem_pop        <= ex_pop;
            mem_out        <= ex_out_port;
            mem_write_back <= ex_write_back;
        end
    end

    always_ff @(posedge clk) begin
        mem_dest        <= ex_dest;
        mem_result      <= result;
        mem_store_value <= ex_dest_value;  // Store, push and OUT data
    end

endmodule

// File: register_file.sv
module register_file (
    input  logic               clk,
    input  logic               rst,
    input  cpu_pkg::reg_addr_t src_addr,
    input  cpu_pkg::reg_addr_t dest_addr,
    input  logic               wb_enable,
    input  cpu_pkg::reg_addr_t wb_addr,
    input  cpu_pkg::word_t     wb_data,
    output cpu_pkg::word_t     src_value,
    output cpu_pkg::word_t     dest_value
);

    cpu_pkg::word_t regs [8];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_enable) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Write-through so a reader sees this cycle's write
    assign src_value  = (wb_enable && wb_addr == src_addr)  ? wb_data : regs[src_addr];
    assign dest_value = (wb_enable && wb_addr == dest_addr) ? wb_data : regs[dest_addr];

endmodule

// File: control_decode.sv
module control_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  cpu_pkg::word_t         instr,
    input  logic                   instr_valid,
    input  logic                   jump_taken,
    input  cpu_pkg::word_t         src_value,
    input  cpu_pkg::word_t         dest_value,
    output cpu_pkg::reg_addr_t     src_addr,
    output cpu_pkg::reg_addr_t     dest_addr,
    output logic                   ex_valid,
    output cpu_pkg::alu_op_t       ex_alu_op,
    output logic                   ex_mem_read,
    output logic                   ex_mem_write,
    output logic                   ex_push,
    output logic                   ex_pop,
    output logic                   ex_in_port,
    output logic                   ex_out_port,
    output cpu_pkg::jump_kind_t    ex_jump_kind,
    output logic                   ex_jump_direct,
    output logic                   ex_write_back,
    output cpu_pkg::reg_addr_t     ex_dest,
    output cpu_pkg::word_t         ex_src_value,
    output cpu_pkg::word_t         ex_dest_value,
    output cpu_pkg::word_t         ex_imm
);

    cpu_pkg::decode_state_t state;
    cpu_pkg::word_t         held_word;  // Opcode word waiting for its immediate
    cpu_pkg::word_t         active;
    cpu_pkg::opcode_t       opcode;
    cpu_pkg::alu_op_t       dec_alu_op;
    cpu_pkg::jump_kind_t    dec_jump_kind;
    logic dec_mem_read, dec_mem_write, dec_push, dec_pop;
    logic dec_in, dec_out, dec_direct, dec_write_back;
    logic needs_imm;
    logic issue;

    assign active    = (state == cpu_pkg::DEC_IMMEDIATE) ? held_word : instr;
    assign opcode    = active[15:11];
    assign dest_addr = active[10:8];
    assign src_addr  = active[7:5];

    assign needs_imm = (opcode == cpu_pkg::OP_LDM) || (opcode == cpu_pkg::OP_SHL) ||
                       (opcode == cpu_pkg::OP_SHR);
    // Immediate ops issue only once their second word shows up
    assign issue = instr_valid && !jump_taken &&
                   ((state == cpu_pkg::DEC_IMMEDIATE) || !needs_imm);

    always_comb begin
        dec_alu_op    = cpu_pkg::ALU_NONE;
        dec_jump_kind = cpu_pkg::JUMP_NONE;
        dec_mem_read  = 1'b0;
        dec_mem_write = 1'b0;
        dec_push      = 1'b0;
        dec_pop       = 1'b0;
        dec_in        = 1'b0;
        dec_out       = 1'b0;
        dec_direct    = 1'b0;
        case (opcode)
            cpu_pkg::OP_NOP:   dec_alu_op = cpu_pkg::ALU_NONE;
            cpu_pkg::OP_SETC:  dec_alu_op = cpu_pkg::ALU_SETC;
            cpu_pkg::OP_CLRC:  dec_alu_op = cpu_pkg::ALU_CLRC;
            cpu_pkg::OP_NOT:   dec_alu_op = cpu_pkg::ALU_NOT;
            cpu_pkg::OP_INC:   dec_alu_op = cpu_pkg::ALU_INC;
            cpu_pkg::OP_DEC:   dec_alu_op = cpu_pkg::ALU_DEC;
            cpu_pkg::OP_IN:    dec_in = 1'b1;
            cpu_pkg::OP_OUT:   dec_out = 1'b1;
            cpu_pkg::OP_PUSH: begin
                dec_push   = 1'b1;
                dec_alu_op = cpu_pkg::ALU_ADDR;
            end
            cpu_pkg::OP_POP: begin
                dec_pop      = 1'b1;
                dec_mem_read = 1'b1;
                dec_alu_op   = cpu_pkg::ALU_ADDR;
            end
            cpu_pkg::OP_LOAD: begin
                dec_mem_read = 1'b1;
                dec_alu_op   = cpu_pkg::ALU_ADDR;
            end
            cpu_pkg::OP_STORE: begin
                dec_mem_write = 1'b1;
                dec_alu_op    = cpu_pkg::ALU_ADDR;
            end
            cpu_pkg::OP_LDM:   dec_alu_op = cpu_pkg::ALU_IMM;
            cpu_pkg::OP_JZ:    dec_jump_kind = cpu_pkg::JUMP_ZERO;
            cpu_pkg::OP_JN:    dec_jump_kind = cpu_pkg::JUMP_NEG;
            cpu_pkg::OP_JC:    dec_jump_kind = cpu_pkg::JUMP_CARRY;
            cpu_pkg::OP_JMP:   dec_direct = 1'b1;
            cpu_pkg::OP_MOV:   dec_alu_op = cpu_pkg::ALU_MOV;
            cpu_pkg::OP_ADD:   dec_alu_op = cpu_pkg::ALU_ADD;
            cpu_pkg::OP_SUB:   dec_alu_op = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_AND:   dec_alu_op = cpu_pkg::ALU_AND;
            cpu_pkg::OP_OR:    dec_alu_op = cpu_pkg::ALU_OR;
            cpu_pkg::OP_SHL:   dec_alu_op = cpu_pkg::ALU_SHL;
            cpu_pkg::OP_SHR:   dec_alu_op = cpu_pkg::ALU_SHR;
            default:           dec_alu_op = cpu_pkg::ALU_NONE;  // Unused codes act as NOP
        endcase
        dec_write_back = (dec_alu_op != cpu_pkg::ALU_NONE || dec_mem_read || dec_in) &&
                         !dec_mem_write && !dec_push &&
                         dec_alu_op != cpu_pkg::ALU_SETC && dec_alu_op != cpu_pkg::ALU_CLRC;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= cpu_pkg::DEC_OPCODE;
            ex_valid       <= 1'b0;
            ex_alu_op      <= cpu_pkg::ALU_NONE;
            ex_mem_read    <= 1'b0;
            ex_mem_write   <= 1'b0;
            ex_push        <= 1'b0;
            ex_pop         <= 1'b0;
            ex_in_port     <= 1'b0;
            ex_out_port    <= 1'b0;
            ex_jump_kind   <= cpu_pkg::JUMP_NONE;
            ex_jump_direct <= 1'b0;
            ex_write_back  <= 1'b0;
        end else begin
            if (jump_taken) begin
                state <= cpu_pkg::DEC_OPCODE;  // Drop a pending immediate op
            end else if (instr_valid) begin
                if (state == cpu_pkg::DEC_OPCODE && needs_imm) begin
                    state <= cpu_pkg::DEC_IMMEDIATE;
                end else begin
                    state <= cpu_pkg::DEC_OPCODE;
                end
            end
            ex_valid       <= issue;
            ex_alu_op      <= dec_alu_op;
            ex_mem_read    <= dec_mem_read;
            ex_mem_write   <= dec_mem_write;
            ex_push        <= dec_push;
            ex_pop         <= dec_pop;
            ex_in_port     <= dec_in;
            ex_out_port    <= dec_out;
            ex_jump_kind   <= dec_jump_kind;
            ex_jump_direct <= dec_direct;
            ex_write_back  <= dec_write_back;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid && state == cpu_pkg::DEC_OPCODE) begin
            held_word <= instr;
        end
        ex_dest       <= dest_addr;
        ex_src_value  <= src_value;
        ex_dest_value <= dest_value;
        ex_imm        <= instr;  // Second word of an immediate pair
    end

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

    typedef logic [15:0] word_t;      // Data and instruction word
    typedef logic [2:0]  reg_addr_t;  // General register number
    typedef logic [4:0]  opcode_t;    // Instruction bits 15..11
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  jump_kind_t;

    // Opcode table
    localparam opcode_t OP_NOP   = 5'd0;
    localparam opcode_t OP_SETC  = 5'd1;
    localparam opcode_t OP_CLRC  = 5'd2;
    localparam opcode_t OP_NOT   = 5'd3;
    localparam opcode_t OP_INC   = 5'd4;
    localparam opcode_t OP_DEC   = 5'd5;
    localparam opcode_t OP_IN    = 5'd6;
    localparam opcode_t OP_OUT   = 5'd7;
    localparam opcode_t OP_PUSH  = 5'd8;
    localparam opcode_t OP_POP   = 5'd9;
    localparam opcode_t OP_LOAD  = 5'd10;
    localparam opcode_t OP_STORE = 5'd12;
    localparam opcode_t OP_LDM   = 5'd14;
    localparam opcode_t OP_JZ    = 5'd16;
    localparam opcode_t OP_JN    = 5'd17;
    localparam opcode_t OP_JC    = 5'd18;
    localparam opcode_t OP_JMP   = 5'd19;
    localparam opcode_t OP_MOV   = 5'd24;
    localparam opcode_t OP_ADD   = 5'd25;
    localparam opcode_t OP_SUB   = 5'd26;
    localparam opcode_t OP_AND   = 5'd28;
    localparam opcode_t OP_OR    = 5'd29;
    localparam opcode_t OP_SHL   = 5'd30;
    localparam opcode_t OP_SHR   = 5'd31;

    // ALU operations
    localparam alu_op_t ALU_NONE = 4'd0;
    localparam alu_op_t ALU_NOT  = 4'd1;
    localparam alu_op_t ALU_INC  = 4'd2;
    localparam alu_op_t ALU_DEC  = 4'd3;
    localparam alu_op_t ALU_MOV  = 4'd4;
    localparam alu_op_t ALU_ADD  = 4'd5;
    localparam alu_op_t ALU_SUB  = 4'd6;
    localparam alu_op_t ALU_AND  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_SHL  = 4'd9;
    localparam alu_op_t ALU_SHR  = 4'd10;
    localparam alu_op_t ALU_SETC = 4'd11;
    localparam alu_op_t ALU_CLRC = 4'd12;
    localparam alu_op_t ALU_ADDR = 4'd13;  // Address pass-through
    localparam alu_op_t ALU_IMM  = 4'd14;  // Immediate pass-through

    // Conditional jump types
    localparam jump_kind_t JUMP_NONE  = 2'd0;
    localparam jump_kind_t JUMP_ZERO  = 2'd1;
    localparam jump_kind_t JUMP_NEG   = 2'd2;
    localparam jump_kind_t JUMP_CARRY = 2'd3;

    typedef enum logic {
        DEC_OPCODE,     // Expecting an opcode word
        DEC_IMMEDIATE   // Holding LDM/SHL/SHR for its immediate
    } decode_state_t;

endpackage
